/* logic/ex_cfg.svh */
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// datapath and pc width
`define XLEN 32

// architectural integer registers, x0 included
`define REG_NUM 32

// forward source select codes
// operand straight from the register file
`define FW_RF 2'd0
// ex/mem register, youngest producer
`define FW_EX 2'd1
// mem/wb register
`define FW_LS 2'd2
// wb register, covers the write in the same cycle
`define FW_WB 2'd3

`endif

/* logic/ex_pkg.sv */
`include "ex_cfg.svh"

package ex_pkg;

    // data and pc word
    typedef logic [`XLEN-1:0] xlen_t;
    // register index
    typedef logic [$clog2(`REG_NUM)-1:0] reg_addr_t;
    // forward source select, codes in ex_cfg.svh
    typedef logic [1:0] fwd_sel_t;
    // branch condition field of the instruction
    typedef logic [2:0] funct3_t;

    // integer alu operations
    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_SLL  = 5'd2,
        ALU_SLT  = 5'd3,
        ALU_SLTU = 5'd4,
        ALU_XOR  = 5'd5,
        ALU_SRL  = 5'd6,
        ALU_SRA  = 5'd7,
        ALU_OR   = 5'd8,
        ALU_AND  = 5'd9,
        // pass src2 through, used by lui
        ALU_LUI  = 5'd10
    } alu_op_e;

    // second alu source, any code with bit 1 set means constant 4
    typedef enum logic [1:0] {
        SRC2_RS2  = 2'd0,
        SRC2_IMM  = 2'd1,
        SRC2_FOUR = 2'd2
    } src2_sel_e;

    // decoded micro-op entering execute
    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        funct3_t   funct3;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      rd_we;
        alu_op_e   alu_op;
        logic      src1_is_pc;
        src2_sel_e src2_sel;
        xlen_t     imm;
        logic      is_jal;
        logic      is_jalr;
        logic      is_brc;
    } uop_t;

    // execute result, carried down the result pipe
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      rd_we;
        xlen_t     alures;
        // store operand after forwarding
        xlen_t     rs2;
        xlen_t     pc_next;
        logic      is_jump;
    } res_t;

endpackage

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
    input  ex_pkg::alu_op_e alu_op_i,
    input  ex_pkg::xlen_t   src1_i,
    input  ex_pkg::xlen_t   src2_i,
    output ex_pkg::xlen_t   res_o
);

    import ex_pkg::*;

    // rv32i shifts only look at the low five bits
    logic [4:0] shamt;

    assign shamt = src2_i[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD: begin
                res_o = src1_i + src2_i;
            end
            ALU_SUB: begin
                res_o = src1_i - src2_i;
            end
            ALU_SLL: begin
                res_o = src1_i << shamt;
            end
            // signed less-than, result is 0 or 1
            ALU_SLT: begin
                res_o = xlen_t'($signed(src1_i) < $signed(src2_i));
            end
            ALU_SLTU: begin
                res_o = xlen_t'(src1_i < src2_i);
            end
            ALU_XOR: begin
                res_o = src1_i ^ src2_i;
            end
            ALU_SRL: begin
                res_o = src1_i >> shamt;
            end
            // arithmetic shift keeps the sign bit
            ALU_SRA: begin
                res_o = xlen_t'($signed(src1_i) >>> shamt);
            end
            ALU_OR: begin
                res_o = src1_i | src2_i;
            end
            ALU_AND: begin
                res_o = src1_i & src2_i;
            end
            // lui, immediate already shifted by decode
            ALU_LUI: begin
                res_o = src2_i;
            end
            default: begin
                res_o = '0;
            end
        endcase
    end

endmodule

/* logic/bcu.sv */
`timescale 1ns/1ps

module bcu (
    input  ex_pkg::xlen_t   rs1_i,
    input  ex_pkg::xlen_t   rs2_i,
    input  ex_pkg::xlen_t   imm_i,
    input  ex_pkg::xlen_t   pc_i,
    input  ex_pkg::funct3_t funct3_i,
    input  logic            is_jal_i,
    input  logic            is_jalr_i,
    input  logic            is_brc_i,
    output ex_pkg::xlen_t   pc_next_o,
    output logic            is_jump_o
);

    import ex_pkg::*;

    // branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    logic  cond;
    logic  taken;
    xlen_t jalr_tgt;

    always_comb begin
        case (funct3_i)
            F3_BEQ:  cond = (rs1_i == rs2_i);
            F3_BNE:  cond = (rs1_i != rs2_i);
            F3_BLT:  cond = ($signed(rs1_i) < $signed(rs2_i));
            F3_BGE:  cond = ($signed(rs1_i) >= $signed(rs2_i));
            F3_BLTU: cond = (rs1_i < rs2_i);
            F3_BGEU: cond = (rs1_i >= rs2_i);
            // 010 and 011 are not branches
            default: cond = 1'b0;
        endcase
    end

    assign taken = is_brc_i & cond;

    // jalr target has bit 0 forced low
    assign jalr_tgt = (rs1_i + imm_i) & ~xlen_t'(1);

    always_comb begin
        if (is_jalr_i) begin
            pc_next_o = jalr_tgt;
        end else if (is_jal_i || taken) begin
            pc_next_o = pc_i + imm_i;
        end else begin
            pc_next_o = pc_i + xlen_t'(4);
        end
    end

    assign is_jump_o = is_jal_i | is_jalr_i | taken;

endmodule

/* logic/ex_stage.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_stage (
    input  ex_pkg::uop_t     uop_i,
    input  ex_pkg::xlen_t    rf_rs1_i,
    input  ex_pkg::xlen_t    rf_rs2_i,
    input  ex_pkg::fwd_sel_t rs1_sel_i,
    input  ex_pkg::fwd_sel_t rs2_sel_i,
    input  ex_pkg::xlen_t    ex_fw_i,
    input  ex_pkg::xlen_t    ls_fw_i,
    input  ex_pkg::xlen_t    wb_fw_i,
    output ex_pkg::res_t     res_o
);

    import ex_pkg::*;

    // operands after forwarding
    xlen_t     rs1;
    xlen_t     rs2;
    // alu sources
    xlen_t     src1;
    xlen_t     src2;
    logic [1:0] src2_code;
    xlen_t     alures;
    xlen_t     pc_next;
    logic      is_jump;

    // same four-way pick for both sources
    function automatic xlen_t fwd_mux(input fwd_sel_t sel, input xlen_t rf_val,
                                      input xlen_t ex_val, input xlen_t ls_val,
                                      input xlen_t wb_val);
        xlen_t val;
        case (sel)
            `FW_EX:  val = ex_val;
            `FW_LS:  val = ls_val;
            `FW_WB:  val = wb_val;
            default: val = rf_val;
        endcase
        return val;
    endfunction

    assign rs1 = fwd_mux(rs1_sel_i, rf_rs1_i, ex_fw_i, ls_fw_i, wb_fw_i);
    assign rs2 = fwd_mux(rs2_sel_i, rf_rs2_i, ex_fw_i, ls_fw_i, wb_fw_i);

    // auipc and jumps take the pc
    assign src1 = uop_i.src1_is_pc ? uop_i.pc : rs1;

    // bit 1 set means the link constant
    assign src2_code = uop_i.src2_sel;
    assign src2 = src2_code[1] ? xlen_t'(4) :
                  src2_code[0] ? uop_i.imm  : rs2;

    alu i_alu (
        .alu_op_i (uop_i.alu_op),
        .src1_i   (src1),
        .src2_i   (src2),
        .res_o    (alures)
    );

    // compares forwarded values, not raw regfile data
    bcu i_bcu (
        .rs1_i     (rs1),
        .rs2_i     (rs2),
        .imm_i     (uop_i.imm),
        .pc_i      (uop_i.pc),
        .funct3_i  (uop_i.funct3),
        .is_jal_i  (uop_i.is_jal),
        .is_jalr_i (uop_i.is_jalr),
        .is_brc_i  (uop_i.is_brc),
        .pc_next_o (pc_next),
        .is_jump_o (is_jump)
    );

    always_comb begin
        res_o.valid   = uop_i.valid;
        res_o.rd      = uop_i.rd;
        res_o.rd_we   = uop_i.rd_we;
        res_o.alures  = alures;
        // store data keeps rs2 even when src2 is the immediate
        res_o.rs2     = rs2;
        res_o.pc_next = pc_next;
        // a bubble never redirects
        res_o.is_jump = is_jump & uop_i.valid;
    end

endmodule

/* logic/fwd_unit.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module fwd_unit (
    input  ex_pkg::reg_addr_t rs1_addr_i,
    input  ex_pkg::reg_addr_t rs2_addr_i,
    input  ex_pkg::res_t      ex_i,
    input  ex_pkg::res_t      ls_i,
    input  ex_pkg::res_t      wb_i,
    output ex_pkg::fwd_sel_t  rs1_sel_o,
    output ex_pkg::fwd_sel_t  rs2_sel_o
);

    import ex_pkg::*;

    // stage holds a live write to src
    // bubbles and x0 writes never match
    function automatic logic stage_hit(input res_t stage, input reg_addr_t src);
        return stage.valid && stage.rd_we && (stage.rd != '0) && (stage.rd == src);
    endfunction

    // youngest producer first
    function automatic fwd_sel_t pick_src(input reg_addr_t src, input res_t ex_s,
                                          input res_t ls_s, input res_t wb_s);
        fwd_sel_t sel;
        if (stage_hit(ex_s, src)) begin
            sel = `FW_EX;
        end else if (stage_hit(ls_s, src)) begin
            sel = `FW_LS;
        end else if (stage_hit(wb_s, src)) begin
            sel = `FW_WB;
        end else begin
            sel = `FW_RF;
        end
        return sel;
    endfunction

    assign rs1_sel_o = pick_src(rs1_addr_i, ex_i, ls_i, wb_i);
    assign rs2_sel_o = pick_src(rs2_addr_i, ex_i, ls_i, wb_i);

endmodule

/* logic/regfile.sv */
`timescale 1ns/1ps
`include "ex_cfg.svh"

module regfile (
    input  logic              clk,
    input  logic              rst_n_i,
    input  ex_pkg::reg_addr_t rd1_addr_i,
    input  ex_pkg::reg_addr_t rd2_addr_i,
    output ex_pkg::xlen_t     rd1_data_o,
    output ex_pkg::xlen_t     rd2_data_o,
    input  logic              we_i,
    input  ex_pkg::reg_addr_t wr_addr_i,
    input  ex_pkg::xlen_t     wr_data_i
);

    import ex_pkg::*;

    xlen_t regs [`REG_NUM];

    // writes to x0 are dropped
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // no bypass here, the wb forward path covers a same-cycle write
    assign rd1_data_o = (rd1_addr_i == '0) ? '0 : regs[rd1_addr_i];
    assign rd2_data_o = (rd2_addr_i == '0) ? '0 : regs[rd2_addr_i];

endmodule

/* logic/result_pipe.sv */
`timescale 1ns/1ps

module result_pipe (
    input  logic         clk,
    input  logic         rst_n_i,
    input  ex_pkg::res_t res_i,
    output ex_pkg::res_t ex_q_o,
    output ex_pkg::res_t ls_q_o,
    output ex_pkg::res_t wb_q_o
);

    import ex_pkg::*;

    // ex/mem, mem/wb and wb stages
    res_t ex_q;
    res_t ls_q;
    res_t wb_q;

    // ex/mem register, loads every cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_q <= '0;
        end else begin
            ex_q <= res_i;
        end
    end

    // ls stage only carries the result, no data memory
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ls_q <= '0;
        end else begin
            ls_q <= ex_q;
        end
    end

    // wb register drives the regfile write port
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_q <= '0;
        end else begin
            wb_q <= ls_q;
        end
    end

    // forward taps
    assign ex_q_o = ex_q;
    assign ls_q_o = ls_q;
    assign wb_q_o = wb_q;

endmodule

/* logic/ex_top.sv */
`timescale 1ns/1ps

module ex_top (
    input  logic              clk,
    input  logic              rst_n_i,
    input  ex_pkg::uop_t      uop_i,
    output logic              valid_o,
    output ex_pkg::reg_addr_t rd_o,
    output ex_pkg::xlen_t     alures_o,
    output ex_pkg::xlen_t     rs2_o,
    output ex_pkg::xlen_t     pc_next_o,
    output logic              is_jump_o
);

    import ex_pkg::*;

    // register file read data
    xlen_t    rf_rs1;
    xlen_t    rf_rs2;
    // forward selects
    fwd_sel_t rs1_sel;
    fwd_sel_t rs2_sel;
    // combinational execute result
    res_t     ex_res;
    // pipeline taps
    res_t     ex_q;
    res_t     ls_q;
    res_t     wb_q;

    // writeback from the last stage, x0 filtered in regfile
    regfile i_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd1_addr_i (uop_i.rs1),
        .rd2_addr_i (uop_i.rs2),
        .rd1_data_o (rf_rs1),
        .rd2_data_o (rf_rs2),
        .we_i       (wb_q.valid & wb_q.rd_we),
        .wr_addr_i  (wb_q.rd),
        .wr_data_i  (wb_q.alures)
    );

    fwd_unit i_fwd_unit (
        .rs1_addr_i (uop_i.rs1),
        .rs2_addr_i (uop_i.rs2),
        .ex_i       (ex_q),
        .ls_i       (ls_q),
        .wb_i       (wb_q),
        .rs1_sel_o  (rs1_sel),
        .rs2_sel_o  (rs2_sel)
    );

    ex_stage i_ex_stage (
        .uop_i     (uop_i),
        .rf_rs1_i  (rf_rs1),
        .rf_rs2_i  (rf_rs2),
        .rs1_sel_i (rs1_sel),
        .rs2_sel_i (rs2_sel),
        .ex_fw_i   (ex_q.alures),
        .ls_fw_i   (ls_q.alures),
        .wb_fw_i   (wb_q.alures),
        .res_o     (ex_res)
    );

    result_pipe i_result_pipe (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .res_i   (ex_res),
        .ex_q_o  (ex_q),
        .ls_q_o  (ls_q),
        .wb_q_o  (wb_q)
    );

    // outputs come straight from ex/mem
    assign valid_o   = ex_q.valid;
    assign rd_o      = ex_q.rd;
    assign alures_o  = ex_q.alures;
    assign rs2_o     = ex_q.rs2;
    assign pc_next_o = ex_q.pc_next;
    assign is_jump_o = ex_q.is_jump;

endmodule

/* tb/ex_top_checker.sv */
`timescale 1ns/1ps

module ex_top_checker (
    input logic              clk,
    input logic              rst_n_i,
    input ex_pkg::uop_t      uop_i,
    input logic              valid_o,
    input ex_pkg::reg_addr_t rd_o,
    input ex_pkg::xlen_t     alures_o,
    input ex_pkg::xlen_t     rs2_o,
    input ex_pkg::xlen_t     pc_next_o,
    input logic              is_jump_o
);

    // result pipe is cleared while reset is held
    a_idle_in_reset: assert property (@(posedge clk) !rst_n_i |-> !valid_o)
        else $error("valid_o high while reset is asserted");

    // redirect only from a live result
    a_jump_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        is_jump_o |-> valid_o)
        else $error("is_jump_o high without valid_o");

    // bubble in, bubble out of ex/mem
    a_bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
        !uop_i.valid |=> !valid_o)
        else $error("bubble came out with valid_o high");

    a_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_o |-> !$isunknown({rd_o, alures_o, rs2_o, pc_next_o, is_jump_o}))
        else $error("unknown value on an output while valid_o is high");

endmodule

bind ex_top ex_top_checker i_ex_top_checker (.*);

/* tb/ex_top_tb.sv */
`timescale 1ns/1ps

module ex_top_tb;

    import ex_pkg::*;

    localparam int RST_CYCLES = 10;
    // cycles allowed past the table and reset
    localparam int SLACK = 20;

    logic      clk;
    logic      rst_n_i;
    logic      valid_o;
    logic      is_jump_o;
    uop_t      uop_i;
    reg_addr_t rd_o;
    xlen_t     alures_o;
    xlen_t     rs2_o;
    xlen_t     pc_next_o;

    // stimulus rows and what the model expects from them
    uop_t   uop_tab[$];
    res_t   exp_tab[$];
    // architectural registers in program order
    xlen_t  model_regs [32];
    integer seed;
    int     cycles;

    ex_top i_ex_top (.*);

    // 20 ns clock that also counts rising edges for the timeout
    initial begin
        clk = 1'b0;
        cycles = 0;
        forever begin
            #10 clk = ~clk;
            if (clk) begin
                cycles++;
            end
            if (cycles > uop_tab.size() + RST_CYCLES + SLACK) begin
                $display("timeout: the run did not finish within %0d cycles", cycles - 1);
                $display("Test failed");
                $fatal(1, "timeout");
            end
        end
    end

    function automatic xlen_t alu_model(input alu_op_e op, input xlen_t a, input xlen_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << b[4:0];
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            // lui passes the immediate
            default:  return b;
        endcase
    endfunction

    function automatic logic branch_taken(input funct3_t f3, input xlen_t a, input xlen_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // kind 0 plain, 1 jal, 2 jalr, 3 conditional branch
    // s2 0 rs2, 1 imm, 2 constant 4
    task automatic add_row(input logic vld, input alu_op_e op, input int rd, input int rs1,
                           input int rs2, input int s2, input logic use_pc, input int kind,
                           input int f3, input xlen_t imm);
        uop_t  u;
        res_t  e;
        xlen_t src1;
        xlen_t src2;
        logic  taken;
        u = '{valid: vld, pc: xlen_t'($random(seed)) & 32'hffff_fffc,
              funct3: funct3_t'(f3), rs1: reg_addr_t'(rs1), rs2: reg_addr_t'(rs2),
              rd: reg_addr_t'(rd), rd_we: kind != 3, alu_op: op, src1_is_pc: use_pc,
              src2_sel: src2_sel_e'(s2), imm: imm, is_jal: kind == 1,
              is_jalr: kind == 2, is_brc: kind == 3};
        src1 = use_pc ? u.pc : model_regs[rs1];
        src2 = (s2 >= 2) ? 32'd4 : (s2 == 1) ? imm : model_regs[rs2];
        taken = (kind == 3) && branch_taken(u.funct3, model_regs[rs1], model_regs[rs2]);
        e = '{valid: vld, rd: u.rd, rd_we: u.rd_we, alures: alu_model(op, src1, src2),
              rs2: model_regs[rs2], pc_next: u.pc + 32'd4,
              is_jump: vld && (kind == 1 || kind == 2 || taken)};
        // jalr target drops bit 0
        if (kind == 2) begin
            e.pc_next = (model_regs[rs1] + imm) & ~32'd1;
        end else if (kind == 1 || taken) begin
            e.pc_next = u.pc + imm;
        end
        // bubbles, branches and x0 leave the state alone
        if (vld && u.rd_we && rd != 0) begin
            model_regs[rd] = e.alures;
        end
        uop_tab.push_back(u);
        exp_tab.push_back(e);
    endtask

    task automatic build_table();
        int conds[6] = '{0, 1, 4, 5, 6, 7};
        // operands loaded with addi from x0
        add_row(1, ALU_ADD, 1, 0, 0, 1, 0, 0, 0, $random(seed));
        add_row(1, ALU_ADD, 2, 0, 0, 1, 0, 0, 0, $random(seed));
        // each alu op on two registers and then on an immediate
        for (int op = 0; op <= 10; op++) begin
            add_row(1, alu_op_e'(op), 5 + op, 1, 2, 0, 0, 0, 0, 0);
            add_row(1, alu_op_e'(op), 5 + op, 1, 2, 1, 0, 0, 0, $random(seed));
        end
        // x21 written twice and read at distance one, two and three
        add_row(1, ALU_ADD, 21, 0, 0, 1, 0, 0, 0, $random(seed));
        add_row(1, ALU_ADD, 21, 21, 0, 1, 0, 0, 0, $random(seed));
        add_row(1, ALU_SUB, 22, 21, 1, 0, 0, 0, 0, 0);
        // bubble aimed at x21 must not forward
        add_row(0, ALU_ADD, 21, 0, 0, 1, 0, 0, 0, $random(seed));
        add_row(1, ALU_XOR, 23, 22, 21, 0, 0, 0, 0, 0);
        add_row(0, ALU_ADD, 23, 0, 0, 1, 0, 0, 0, $random(seed));
        add_row(0, ALU_ADD, 21, 0, 0, 1, 0, 0, 0, $random(seed));
        add_row(1, ALU_ADD, 24, 23, 21, 0, 0, 0, 0, 0);
        // x0 write is dropped so the reader right after sees zero
        add_row(1, ALU_ADD, 0, 1, 0, 1, 0, 0, 0, $random(seed));
        add_row(1, ALU_OR, 25, 0, 1, 0, 0, 0, 0, 0);
        // first branches take x26 from the forward taps
        add_row(1, ALU_ADD, 26, 1, 0, 0, 0, 0, 0, 0);
        foreach (conds[c]) begin
            add_row(1, ALU_SUB, 0, 26, 2, 0, 0, 3, conds[c], $random(seed));
            add_row(1, ALU_SUB, 0, 2, 26, 0, 0, 3, conds[c], $random(seed));
            add_row(1, ALU_SUB, 0, 26, 1, 0, 0, 3, conds[c], $random(seed));
        end
        // jal then jalr on the fresh link and jalr with an odd offset
        add_row(1, ALU_ADD, 27, 0, 0, 2, 1, 1, 0, $random(seed));
        add_row(1, ALU_ADD, 28, 27, 0, 2, 1, 2, 0, $random(seed));
        add_row(1, ALU_ADD, 29, 1, 0, 2, 1, 2, 0, $random(seed) | 1);
        // bubble jal must not redirect
        add_row(0, ALU_ADD, 27, 0, 0, 2, 1, 1, 0, $random(seed));
        // store data follows rs2 while src2 takes the immediate
        add_row(1, ALU_ADD, 30, 0, 0, 1, 0, 0, 0, $random(seed));
        add_row(1, ALU_ADD, 0, 1, 30, 1, 0, 0, 0, $random(seed));
    endtask

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            $display("Test failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    initial begin
        string name;
        int    n;
        rst_n_i = 1'b1;
        uop_i = '0;
        seed = 10113;
        model_regs = '{default: '0};
        build_table();
        n = uop_tab.size();
        // falling edge starts the async clear
        #1 rst_n_i = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        // row i goes in while row i-1 sits in ex/mem
        for (int i = 0; i <= n; i++) begin
            @(posedge clk);
            uop_i <= (i < n) ? uop_tab[i] : uop_t'('0);
            if (i > 0) begin
                @(negedge clk);
                name = $sformatf("row %0d", i - 1);
                check_val({name, " valid"}, 32'(exp_tab[i-1].valid), 32'(valid_o));
                check_val({name, " is_jump"}, 32'(exp_tab[i-1].is_jump), 32'(is_jump_o));
                if (exp_tab[i-1].valid) begin
                    check_val({name, " rd"}, 32'(exp_tab[i-1].rd), 32'(rd_o));
                    check_val({name, " alures"}, exp_tab[i-1].alures, alures_o);
                    check_val({name, " rs2"}, exp_tab[i-1].rs2, rs2_o);
                    check_val({name, " pc_next"}, exp_tab[i-1].pc_next, pc_next_o);
                end
            end
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* compile.f */
+incdir+logic
logic/ex_pkg.sv
logic/alu.sv
logic/bcu.sv
logic/ex_stage.sv
logic/fwd_unit.sv
logic/regfile.sv
logic/result_pipe.sv
logic/ex_top.sv
tb/ex_top_checker.sv
tb/ex_top_tb.sv
